// File: hdl/isa_pkg.sv
/*
 * Architectural definitions of the front end
 *   ARCH_REGS    number of architectural registers
 *   arch_idx_t   architectural register number
 *   opcode_t     instruction classes seen by decode
 */
`default_nettype none

package isa_pkg;

    localparam int ARCH_REGS = 32;              // Register 0 keeps its mapping

    typedef logic [$clog2(ARCH_REGS)-1:0] arch_idx_t;

    // Instruction classes
    typedef enum logic [2:0] {
        OP_ALU    = 3'd0,                       // Integer ALU, writes rd
        OP_MULT   = 3'd1,                       // Multiply, writes rd
        OP_LOAD   = 3'd2,                       // Load, writes rd, reads rs1 only
        OP_STORE  = 3'd3,                       // Store, no destination
        OP_BRANCH = 3'd4                        // Branch, no destination
    } opcode_t;

endpackage

`default_nettype wire

// File: hdl/core_pkg.sv
/*
 * Microarchitecture definitions of the rename front end
 *   PHYS_REGS    size of the physical register space
 *   phys_tag_t   physical register tag
 *   FREE_REGS    tags held by the free list after reset
 */
`default_nettype none

package core_pkg;

    localparam int PHYS_REGS = 64;

    typedef logic [$clog2(PHYS_REGS)-1:0] phys_tag_t;

    // Tags PHYS_REGS-FREE_REGS .. PHYS_REGS-1 start out free
    localparam int FREE_REGS = 32;

endpackage

`default_nettype wire

// File: hdl/decode_stage.sv
/*
 * Decode stage
 *   Single instruction register at the pipeline input
 *   Register-use flags derived from the opcode and rd
 *   Register holds its contents while stall is high
 */
`default_nettype none
`timescale 1ns/1ns

module decode_stage (
    input  logic                clock,
    input  logic                reset,
    input  logic                in_valid,
    input  isa_pkg::opcode_t    in_op,
    input  isa_pkg::arch_idx_t  in_rd,
    input  isa_pkg::arch_idx_t  in_rs1,
    input  isa_pkg::arch_idx_t  in_rs2,
    input  logic                stall,          // From rename, hold the register
    output logic                dec_valid,
    output isa_pkg::opcode_t    dec_op,
    output isa_pkg::arch_idx_t  dec_rd,
    output isa_pkg::arch_idx_t  dec_rs1,
    output isa_pkg::arch_idx_t  dec_rs2,
    output logic                dec_writes_rd,
    output logic                dec_uses_rs1,
    output logic                dec_uses_rs2
);
    import isa_pkg::*;

    logic writes_rd;                            // Decoded before the register
    logic uses_rs2;

    always_comb begin
        writes_rd = 1'b0;
        uses_rs2  = 1'b0;
        case (in_op)
            OP_ALU, OP_MULT: begin
                writes_rd = (in_rd != '0);      // r0 writes are dropped
                uses_rs2  = 1'b1;
            end
            OP_LOAD:              writes_rd = (in_rd != '0);
            OP_STORE, OP_BRANCH:  uses_rs2 = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset)
            dec_valid <= 1'b0;
        else if (!stall)
            dec_valid <= in_valid;              // Bubble when nothing arrives
    end

    // Payload, qualified by dec_valid
    always_ff @(posedge clock) begin
        if (!stall) begin
            dec_op        <= in_op;
            dec_rd        <= in_rd;
            dec_rs1       <= in_rs1;
            dec_rs2       <= in_rs2;
            dec_writes_rd <= writes_rd;
            dec_uses_rs1  <= 1'b1;              // Every class reads rs1
            dec_uses_rs2  <= uses_rs2;
        end
    end

endmodule

`default_nettype wire

// File: hdl/map_table.sv
/*
 * Speculative register map
 *   Architectural to physical mapping, identity after reset
 *   Busy bit per physical register
 *   Three read ports, one remap port, one completion port
 */
`default_nettype none
`timescale 1ns/1ns

module map_table (
    input  logic                 clock,
    input  logic                 reset,
    input  isa_pkg::arch_idx_t   rd_rs1,
    input  isa_pkg::arch_idx_t   rd_rs2,
    input  isa_pkg::arch_idx_t   rd_dest,
    output core_pkg::phys_tag_t  tag_rs1,
    output core_pkg::phys_tag_t  tag_rs2,
    output core_pkg::phys_tag_t  tag_prev,      // Mapping being replaced
    output logic                 busy_rs1,
    output logic                 busy_rs2,
    input  logic                 write_en,      // Remap rd_dest to write_tag
    input  core_pkg::phys_tag_t  write_tag,
    input  logic                 complete_valid,
    input  core_pkg::phys_tag_t  complete_tag
);
    import isa_pkg::*;
    import core_pkg::*;

    phys_tag_t             map_q [ARCH_REGS];
    logic [PHYS_REGS-1:0]  busy_q;

    // Lookups
    assign tag_rs1  = map_q[rd_rs1];
    assign tag_rs2  = map_q[rd_rs2];
    assign tag_prev = map_q[rd_dest];
    assign busy_rs1 = busy_q[tag_rs1];
    assign busy_rs2 = busy_q[tag_rs2];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ARCH_REGS; i++)
                map_q[i] <= phys_tag_t'(i);     // Register i starts on tag i
            busy_q <= '0;
        end else begin
            if (complete_valid)
                busy_q[complete_tag] <= 1'b0;   // Producer has finished
            // A freshly allocated tag is never in flight, so no clash
            if (write_en) begin
                map_q[rd_dest]    <= write_tag;
                busy_q[write_tag] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/free_list.sv
/*
 * Free list of physical tags
 *   Circular FIFO with head, tail and count
 *   Filled with the upper tags in ascending order at reset
 *   Push and pop allowed in the same cycle
 */
`default_nettype none
`timescale 1ns/1ns

module free_list (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 pop,
    output core_pkg::phys_tag_t  pop_tag,       // Oldest free tag
    output logic                 empty,
    input  logic                 push,
    input  core_pkg::phys_tag_t  push_tag
);
    import core_pkg::*;

    localparam int PTR_W = $clog2(FREE_REGS);
    localparam int CNT_W = $clog2(FREE_REGS + 1);

    phys_tag_t         mem_q [FREE_REGS];
    logic [PTR_W-1:0]  head_q;                  // Next tag to hand out
    logic [PTR_W-1:0]  tail_q;                  // Next slot to fill
    logic [CNT_W-1:0]  count_q;

    assign pop_tag = mem_q[head_q];
    assign empty   = (count_q == '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < FREE_REGS; i++)
                mem_q[i] <= phys_tag_t'(PHYS_REGS - FREE_REGS + i);
            head_q  <= '0;
            tail_q  <= '0;                      // Full, tail wrapped onto head
            count_q <= CNT_W'(FREE_REGS);
        end else begin
            if (push) begin
                mem_q[tail_q] <= push_tag;
                tail_q        <= tail_q + 1'b1;
            end
            if (pop)
                head_q <= head_q + 1'b1;
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;                      // Both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/rename_stage.sv
/*
 * Rename stage, combinational
 *   Stall and fire decision
 *   Source lookup with completion bypass
 *   Destination allocation from the free list
 */
`default_nettype none
`timescale 1ns/1ns

module rename_stage (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 dec_valid,
    input  isa_pkg::opcode_t     dec_op,
    input  isa_pkg::arch_idx_t   dec_rd,
    input  isa_pkg::arch_idx_t   dec_rs1,
    input  isa_pkg::arch_idx_t   dec_rs2,
    input  logic                 dec_writes_rd,
    input  logic                 dec_uses_rs1,
    input  logic                 dec_uses_rs2,
    input  logic                 rob_full,
    input  logic                 complete_valid,
    input  core_pkg::phys_tag_t  complete_tag,
    input  logic                 free_push,     // Tag released by retire
    input  core_pkg::phys_tag_t  free_push_tag,
    output logic                 stall,
    output logic                 fire,
    output isa_pkg::opcode_t     ren_op,
    output core_pkg::phys_tag_t  ren_dest_tag,
    output core_pkg::phys_tag_t  ren_prev_tag,
    output core_pkg::phys_tag_t  ren_src1_tag,
    output logic                 ren_src1_ready,
    output core_pkg::phys_tag_t  ren_src2_tag,
    output logic                 ren_src2_ready
);
    import core_pkg::*;

    phys_tag_t  tag_rs1, tag_rs2, tag_prev, new_tag;
    logic       busy_rs1, busy_rs2, free_empty, alloc;

    ////////////////////////////////////////////////////////////
    // Hazard check and allocation
    ////////////////////////////////////////////////////////////
    assign stall = dec_valid && (rob_full || (dec_writes_rd && free_empty));
    assign fire  = dec_valid && !stall;
    assign alloc = fire && dec_writes_rd;       // Pop and remap together

    map_table u_map (
        .clock, .reset,
        .rd_rs1(dec_rs1), .rd_rs2(dec_rs2), .rd_dest(dec_rd),
        .tag_rs1, .tag_rs2, .tag_prev, .busy_rs1, .busy_rs2,
        .write_en(alloc), .write_tag(new_tag),
        .complete_valid, .complete_tag
    );

    free_list u_free (
        .clock, .reset,
        .pop(alloc), .pop_tag(new_tag), .empty(free_empty),
        .push(free_push), .push_tag(free_push_tag)
    );

    ////////////////////////////////////////////////////////////
    // Renamed fields
    ////////////////////////////////////////////////////////////
    assign ren_op       = dec_op;
    assign ren_dest_tag = dec_writes_rd ? new_tag  : '0;    // No dest reports 0
    assign ren_prev_tag = dec_writes_rd ? tag_prev : '0;

    // Unused source is tag 0 and ready, busy tag ready only on a same-cycle completion
    assign ren_src1_tag   = dec_uses_rs1 ? tag_rs1 : '0;
    assign ren_src1_ready = !dec_uses_rs1 || !busy_rs1 ||
                            (complete_valid && (complete_tag == tag_rs1));
    assign ren_src2_tag   = dec_uses_rs2 ? tag_rs2 : '0;
    assign ren_src2_ready = !dec_uses_rs2 || !busy_rs2 ||
                            (complete_valid && (complete_tag == tag_rs2));

endmodule

`default_nettype wire

// File: hdl/dispatch_stage.sv
/*
 * Dispatch stage
 *   ROB of prev tag and has-destination bit, head, tail and count
 *   Registered dispatch pulse carrying the ROB index
 *   In-order retire, freed tag back to the free list, retire report
 */
`default_nettype none
`timescale 1ns/1ns

module dispatch_stage #(
    parameter int ROB_DEPTH = 8                 // Power of two
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          fire,
    input  isa_pkg::opcode_t              ren_op,
    input  core_pkg::phys_tag_t           ren_dest_tag,
    input  core_pkg::phys_tag_t           ren_prev_tag,
    input  core_pkg::phys_tag_t           ren_src1_tag,
    input  logic                          ren_src1_ready,
    input  core_pkg::phys_tag_t           ren_src2_tag,
    input  logic                          ren_src2_ready,
    input  logic                          retire,
    output logic                          rob_full,
    output logic                          free_push,
    output core_pkg::phys_tag_t           free_push_tag,
    output logic                          disp_valid,
    output isa_pkg::opcode_t              disp_op,
    output logic [$clog2(ROB_DEPTH)-1:0]  disp_rob_idx,
    output core_pkg::phys_tag_t           disp_dest_tag,
    output core_pkg::phys_tag_t           disp_prev_tag,
    output core_pkg::phys_tag_t           disp_src1_tag,
    output logic                          disp_src1_ready,
    output core_pkg::phys_tag_t           disp_src2_tag,
    output logic                          disp_src2_ready,
    output logic                          ret_valid,
    output logic [$clog2(ROB_DEPTH)-1:0]  ret_rob_idx,
    output logic                          ret_freed_valid,
    output core_pkg::phys_tag_t           ret_freed_tag
);
    import core_pkg::*;

    localparam int IDX_W = $clog2(ROB_DEPTH);

    phys_tag_t         rob_prev [ROB_DEPTH];    // Mapping to free at retire
    logic              rob_has_dest [ROB_DEPTH];
    logic [IDX_W-1:0]  rob_head, rob_tail;      // Wrap on their own
    logic [IDX_W:0]    rob_count;
    logic              retire_ok;

    assign rob_full      = (rob_count == (IDX_W+1)'(ROB_DEPTH));
    assign retire_ok     = retire && (rob_count != '0);     // Empty ROB ignores it
    assign free_push     = retire_ok && rob_has_dest[rob_head];
    assign free_push_tag = rob_prev[rob_head];

    ////////////////////////////////////////////////////////////
    // Control state
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            rob_head        <= '0;
            rob_tail        <= '0;
            rob_count       <= '0;
            disp_valid      <= 1'b0;
            ret_valid       <= 1'b0;
            ret_freed_valid <= 1'b0;
        end else begin
            disp_valid      <= fire;            // One-cycle pulses
            ret_valid       <= retire_ok;
            ret_freed_valid <= free_push;
            if (fire)      rob_tail <= rob_tail + 1'b1;
            if (retire_ok) rob_head <= rob_head + 1'b1;
            case ({fire, retire_ok})
                2'b10:   rob_count <= rob_count + 1'b1;
                2'b01:   rob_count <= rob_count - 1'b1;
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Entries and report payload
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (fire) begin
            rob_prev[rob_tail]     <= ren_prev_tag;
            rob_has_dest[rob_tail] <= (ren_dest_tag != '0);    // Tag 0 is never allocated
            disp_op         <= ren_op;
            disp_rob_idx    <= rob_tail;
            disp_dest_tag   <= ren_dest_tag;
            disp_prev_tag   <= ren_prev_tag;
            disp_src1_tag   <= ren_src1_tag;
            disp_src1_ready <= ren_src1_ready;
            disp_src2_tag   <= ren_src2_tag;
            disp_src2_ready <= ren_src2_ready;
        end
        if (retire_ok) begin
            ret_rob_idx   <= rob_head;
            ret_freed_tag <= rob_prev[rob_head];
        end
    end

endmodule

`default_nettype wire

// File: hdl/dispatch_top.sv
/*
 * Rename and dispatch front end
 *   Decode, rename and dispatch stages in a row
 *   ROB depth set here and passed to dispatch
 */
`default_nettype none
`timescale 1ns/1ns

module dispatch_top #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          in_valid,
    input  isa_pkg::opcode_t              in_op,
    input  isa_pkg::arch_idx_t            in_rd,
    input  isa_pkg::arch_idx_t            in_rs1,
    input  isa_pkg::arch_idx_t            in_rs2,
    input  logic                          complete_valid,
    input  core_pkg::phys_tag_t           complete_tag,
    input  logic                          retire,
    output logic                          stall,
    output logic                          disp_valid,
    output isa_pkg::opcode_t              disp_op,
    output logic [$clog2(ROB_DEPTH)-1:0]  disp_rob_idx,
    output core_pkg::phys_tag_t           disp_dest_tag,
    output core_pkg::phys_tag_t           disp_prev_tag,
    output core_pkg::phys_tag_t           disp_src1_tag,
    output logic                          disp_src1_ready,
    output core_pkg::phys_tag_t           disp_src2_tag,
    output logic                          disp_src2_ready,
    output logic                          ret_valid,
    output logic [$clog2(ROB_DEPTH)-1:0]  ret_rob_idx,
    output logic                          ret_freed_valid,
    output core_pkg::phys_tag_t           ret_freed_tag
);
    import isa_pkg::*;
    import core_pkg::*;

    // Decode to rename
    logic       dec_valid, dec_writes_rd, dec_uses_rs1, dec_uses_rs2;
    opcode_t    dec_op;
    arch_idx_t  dec_rd, dec_rs1, dec_rs2;

    // Rename to dispatch and back
    logic       fire, rob_full, free_push;
    opcode_t    ren_op;
    phys_tag_t  ren_dest_tag, ren_prev_tag, ren_src1_tag, ren_src2_tag, free_push_tag;
    logic       ren_src1_ready, ren_src2_ready;

    decode_stage u_decode (
        .clock, .reset, .in_valid, .in_op, .in_rd, .in_rs1, .in_rs2, .stall,
        .dec_valid, .dec_op, .dec_rd, .dec_rs1, .dec_rs2,
        .dec_writes_rd, .dec_uses_rs1, .dec_uses_rs2
    );

    rename_stage u_rename (
        .clock, .reset, .dec_valid, .dec_op, .dec_rd, .dec_rs1, .dec_rs2,
        .dec_writes_rd, .dec_uses_rs1, .dec_uses_rs2,
        .rob_full, .complete_valid, .complete_tag, .free_push, .free_push_tag,
        .stall, .fire, .ren_op, .ren_dest_tag, .ren_prev_tag,
        .ren_src1_tag, .ren_src1_ready, .ren_src2_tag, .ren_src2_ready
    );

    dispatch_stage #(.ROB_DEPTH(ROB_DEPTH)) u_dispatch (
        .clock, .reset, .fire, .ren_op, .ren_dest_tag, .ren_prev_tag,
        .ren_src1_tag, .ren_src1_ready, .ren_src2_tag, .ren_src2_ready,
        .retire, .rob_full, .free_push, .free_push_tag,
        .disp_valid, .disp_op, .disp_rob_idx, .disp_dest_tag, .disp_prev_tag,
        .disp_src1_tag, .disp_src1_ready, .disp_src2_tag, .disp_src2_ready,
        .ret_valid, .ret_rob_idx, .ret_freed_valid, .ret_freed_tag
    );

endmodule

`default_nettype wire

// File: test/dispatch_asserts.sv
/*
 * Concurrent checks on the dispatch stage
 *   Quiet dispatch output right after reset
 *   ROB occupancy bound
 *   No dispatch into a full ROB
 */
`default_nettype none
`timescale 1ns/1ns

module dispatch_asserts #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        fire,
    input  logic                        rob_full,
    input  logic                        disp_valid,
    input  logic [$clog2(ROB_DEPTH):0]  rob_count
);

    localparam int CNT_W = $clog2(ROB_DEPTH) + 1;

    // Pulse register is cleared by reset
    a_reset_quiet: assert property (@(posedge clock) reset |=> !disp_valid)
        else $error("disp_valid high in the cycle after reset");

    a_count_bound: assert property (@(posedge clock) disable iff (reset)
        rob_count <= CNT_W'(ROB_DEPTH))
        else $error("ROB count above its depth");

    // Rename must stall on a full ROB
    a_no_fire_full: assert property (@(posedge clock) disable iff (reset)
        !(fire && rob_full))
        else $error("dispatch fired into a full ROB");

endmodule

`default_nettype wire

// File: test/tb_dispatch.sv
/*
 * Testbench of the rename and dispatch front end
 *   Clock, reset and a stimulus table applied one row per cycle
 *   Cycle-level reference model of map, busy bits, free list and ROB
 *   Typed compare tasks, timeout counter and closing summary
 */
`default_nettype none
`timescale 1ns/1ns

module tb_dispatch;
    import isa_pkg::*;
    import core_pkg::*;

    localparam int ROB_DEPTH = 8;
    localparam int IDX_W     = $clog2(ROB_DEPTH);

    logic                clock, reset, in_valid, complete_valid, retire;
    opcode_t             in_op;
    arch_idx_t           in_rd, in_rs1, in_rs2;
    phys_tag_t           complete_tag;
    logic                stall, disp_valid, disp_src1_ready, disp_src2_ready;
    opcode_t             disp_op;
    logic [IDX_W-1:0]    disp_rob_idx, ret_rob_idx;
    phys_tag_t           disp_dest_tag, disp_prev_tag, disp_src1_tag, disp_src2_tag;
    logic                ret_valid, ret_freed_valid;
    phys_tag_t           ret_freed_tag;

    dispatch_top #(.ROB_DEPTH(ROB_DEPTH)) UUT (.*);

    bind dispatch_stage dispatch_asserts #(.ROB_DEPTH(ROB_DEPTH)) u_asserts (
        .clock(clock), .reset(reset), .fire(fire), .rob_full(rob_full),
        .disp_valid(disp_valid), .rob_count(rob_count)
    );

    // Stimulus table with one entry per row in each queue
    int         q_test[$];
    bit         q_valid[$], q_ret[$], q_cv[$];
    opcode_t    q_op[$];
    arch_idx_t  q_rd[$], q_rs1[$], q_rs2[$];
    phys_tag_t  q_ct[$];                        // 0 with cv set picks a busy tag

    // Reference model state
    phys_tag_t    m_map [ARCH_REGS];
    bit           m_busy [PHYS_REGS];
    phys_tag_t    free_q[$];
    logic [6:0]   rob_q[$];                     // {has_dest, prev tag}
    int           m_head, m_tail;
    bit           m_dvalid, m_writes, m_uses2;
    opcode_t      m_op;
    arch_idx_t    m_rd, m_rs1, m_rs2;
    logic [31:0]  exp_disp[$];                  // Expected dispatch pulses
    logic [9:0]   exp_ret[$];                   // Expected retire reports

    int     n_checks, n_errors, cur_test, cycles, limit;
    int     test_errs [6];
    string  test_names [6];

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Timeout counter with its limit set once the table is built
    always @(posedge clock) begin
        cycles++;
        if (limit != 0 && cycles >= limit) begin
            $display("Timeout after %0d cycles, the pipeline did not drain", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////
    task automatic report_err(input string msg);
        $display("ERR %0t: %s", $time, msg);
        n_errors++;
        test_errs[cur_test]++;
    endtask

    task automatic check_tag(input string what, input phys_tag_t got, input phys_tag_t exp);
        n_checks++;
        if (got !== exp) report_err($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_op(input string what, input opcode_t got, input opcode_t exp);
        n_checks++;
        if (got !== exp) report_err($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_idx(input string what, input logic [IDX_W-1:0] got,
                             input logic [IDX_W-1:0] exp);
        n_checks++;
        if (got !== exp) report_err($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) report_err($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    ////////////////////////////////////////////////////////////
    // Table building
    ////////////////////////////////////////////////////////////
    task automatic add_row(input int t, input bit v, input opcode_t op, input int rd,
                           input int rs1, input int rs2, input bit ret, input bit cv,
                           input int ct);
        q_test.push_back(t);
        q_valid.push_back(v);
        q_op.push_back(op);
        q_rd.push_back(arch_idx_t'(rd));
        q_rs1.push_back(arch_idx_t'(rs1));
        q_rs2.push_back(arch_idx_t'(rs2));
        q_ret.push_back(ret);
        q_cv.push_back(cv);
        q_ct.push_back(phys_tag_t'(ct));
    endtask

    task automatic add_idle(input int t, input bit ret, input bit cv, input int ct);
        add_row(t, 1'b0, OP_ALU, 0, 0, 0, ret, cv, ct);
    endtask

    task automatic build_table();
        // Rename chain from the reset mapping
        add_row(1, 1, OP_ALU,  1, 2, 3, 0, 0, 0);
        add_row(1, 1, OP_ALU,  4, 1, 5, 0, 0, 0);
        add_row(1, 1, OP_MULT, 1, 4, 1, 0, 0, 0);
        add_row(1, 1, OP_LOAD, 6, 1, 9, 0, 0, 0);   // rs2 unused
        add_idle(1, 0, 0, 0);
        // No destination cases
        add_row(2, 1, OP_STORE,  0, 6, 4, 1, 0, 0);
        add_row(2, 1, OP_BRANCH, 0, 1, 2, 1, 0, 0);
        add_row(2, 1, OP_ALU,    0, 3, 7, 0, 0, 0); // Write to r0
        add_row(2, 1, OP_LOAD,   0, 0, 0, 0, 0, 0);
        add_idle(2, 1, 0, 0);
        add_idle(2, 1, 0, 0);
        // Readiness and bypass
        add_idle(3, 0, 1, 33);                      // r4 producer done
        add_row(3, 1, OP_ALU, 8, 4, 1, 0, 0, 0);
        add_idle(3, 0, 1, 34);                      // Same cycle as its rename
        add_row(3, 1, OP_ALU, 9, 6, 8, 0, 0, 0);
        add_idle(3, 0, 1, 0);
        add_row(3, 1, OP_MULT, 10, 1, 6, 1, 1, 0);
        add_idle(3, 1, 0, 0);
        // Fill the ROB and stall until one retire releases it
        repeat (8) add_idle(4, 1, 0, 0);
        for (int i = 0; i < 9; i++)
            add_row(4, 1, OP_ALU, 11 + i, i + 1, 31 - i, 0, 0, 0);
        add_idle(4, 0, 0, 0);
        add_idle(4, 0, 0, 0);
        add_row(4, 1, OP_ALU, 20, 11, 12, 1, 0, 0); // Held while stalled
        add_idle(4, 1, 0, 0);
        add_idle(4, 1, 0, 0);
        // Steady retire with tag reuse and index wrap
        repeat (8) add_idle(5, 1, 0, 0);
        for (int i = 0; i < 22; i++)
            add_row(5, 1, OP_ALU, (i % 31) + 1, (i * 7) % 32, (i * 3 + 1) % 32,
                    1, i[0], 0);
        repeat (8) add_idle(5, 1, 0, 0);
    endtask

    ////////////////////////////////////////////////////////////
    // Driving and reference model
    ////////////////////////////////////////////////////////////
    task automatic drive_row(input int r);
        phys_tag_t busy_list[$];
        in_valid       = q_valid[r];
        in_op          = q_op[r];
        in_rd          = q_rd[r];
        in_rs1         = q_rs1[r];
        in_rs2         = q_rs2[r];
        retire         = q_ret[r] && (rob_q.size() != 0);   // Never on an empty ROB
        complete_valid = q_cv[r];
        complete_tag   = q_ct[r];
        if (q_cv[r] && q_ct[r] == '0) begin
            for (int t = 0; t < PHYS_REGS; t++)
                if (m_busy[t]) busy_list.push_back(phys_tag_t'(t));
            if (busy_list.size() == 0)
                complete_valid = 1'b0;
            else
                complete_tag = busy_list[$urandom % busy_list.size()];
        end
    endtask

    task automatic drive_idle();
        in_valid       = 1'b0;
        retire         = 1'b0;
        complete_valid = 1'b0;
    endtask

    // One cycle of the model from the inputs now on the DUT pins
    task automatic model_step(input bit row_valid, output bit advance);
        bit          stall_exp, fire, r1, r2;
        phys_tag_t   s1, s2, dst, prv;
        logic [6:0]  ent;
        stall_exp = m_dvalid && (rob_q.size() == ROB_DEPTH ||
                                 (m_writes && free_q.size() == 0));
        check_flag("stall", stall, stall_exp);
        fire = m_dvalid && !stall_exp;
        if (fire) begin
            s1  = m_map[m_rs1];
            r1  = !m_busy[s1] || (complete_valid && complete_tag == s1);
            s2  = m_uses2 ? m_map[m_rs2] : '0;
            r2  = !m_uses2 || !m_busy[s2] || (complete_valid && complete_tag == s2);
            dst = m_writes ? free_q[0] : '0;        // Oldest free tag
            prv = m_writes ? m_map[m_rd] : '0;
            exp_disp.push_back({m_op, IDX_W'(m_tail), dst, prv, s1, r1, s2, r2});
        end
        if (retire) begin
            ent = rob_q.pop_front();
            exp_ret.push_back({IDX_W'(m_head), ent});
            if (ent[6]) free_q.push_back(ent[5:0]); // Freed tag to the tail
            m_head = (m_head + 1) % ROB_DEPTH;
        end
        if (complete_valid) m_busy[complete_tag] = 1'b0;
        if (fire) begin
            if (m_writes) begin
                free_q.delete(0);
                m_map[m_rd] = dst;
                m_busy[dst] = 1'b1;
            end
            rob_q.push_back({m_writes, prv});
            m_tail = (m_tail + 1) % ROB_DEPTH;
        end
        if (!stall_exp) begin                       // Decode register loads
            m_dvalid = in_valid;
            m_op     = in_op;
            m_rd     = in_rd;
            m_rs1    = in_rs1;
            m_rs2    = in_rs2;
            m_writes = in_valid && in_rd != '0 &&
                       (in_op == OP_ALU || in_op == OP_MULT || in_op == OP_LOAD);
            m_uses2  = (in_op != OP_LOAD);
        end
        advance = !(row_valid && in_valid && stall_exp);
    endtask

    // Registered outputs of the last edge
    task automatic check_outputs();
        logic [31:0] d;
        logic [9:0]  r;
        check_flag("disp_valid", disp_valid, exp_disp.size() != 0);
        if (exp_disp.size() != 0) begin
            d = exp_disp.pop_front();
            check_op("disp_op", disp_op, opcode_t'(d[31:29]));
            check_idx("disp_rob_idx", disp_rob_idx, d[28:26]);
            check_tag("disp_dest_tag", disp_dest_tag, d[25:20]);
            check_tag("disp_prev_tag", disp_prev_tag, d[19:14]);
            check_tag("disp_src1_tag", disp_src1_tag, d[13:8]);
            check_flag("disp_src1_ready", disp_src1_ready, d[7]);
            check_tag("disp_src2_tag", disp_src2_tag, d[6:1]);
            check_flag("disp_src2_ready", disp_src2_ready, d[0]);
        end
        check_flag("ret_valid", ret_valid, exp_ret.size() != 0);
        if (exp_ret.size() != 0) begin
            r = exp_ret.pop_front();
            check_idx("ret_rob_idx", ret_rob_idx, r[9:7]);
            check_flag("ret_freed_valid", ret_freed_valid, r[6]);
            check_tag("ret_freed_tag", ret_freed_tag, r[5:0]);
        end else begin
            check_flag("ret_freed_valid", ret_freed_valid, 1'b0);
        end
    endtask

    task automatic report_test(input int t);
        $display("test %0d %s: %0d errors", t, test_names[t], test_errs[t]);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        int  row;
        bit  advance;
        void'($urandom(32'h533c1974));
        reset          = 1'b1;
        in_valid       = 1'b0;
        in_op          = OP_ALU;
        in_rd          = '0;
        in_rs1         = '0;
        in_rs2         = '0;
        complete_valid = 1'b0;
        complete_tag   = '0;
        retire         = 1'b0;
        test_names = '{"", "rename chain", "no destination", "readiness",
                       "rob full stall", "retire and reuse"};
        build_table();
        limit = 4 * q_valid.size() + 100;
        for (int i = 0; i < ARCH_REGS; i++)
            m_map[i] = phys_tag_t'(i);              // Identity after reset
        for (int i = PHYS_REGS - FREE_REGS; i < PHYS_REGS; i++)
            free_q.push_back(phys_tag_t'(i));
        repeat (10) @(posedge clock);
        #1 reset = 1'b0;

        row      = 0;
        cur_test = q_test[0];
        while (row < q_valid.size() || exp_disp.size() != 0 || exp_ret.size() != 0 ||
               m_dvalid) begin
            check_outputs();
            if (row < q_valid.size()) begin
                if (q_test[row] != cur_test) begin  // Previous test fully checked
                    report_test(cur_test);
                    cur_test = q_test[row];
                end
                drive_row(row);
            end else begin
                drive_idle();
            end
            model_step(row < q_valid.size(), advance);
            if (row < q_valid.size() && advance)
                row++;
            @(posedge clock);
            #1;
        end
        check_outputs();
        report_test(cur_test);

        $display("tests=5 checks=%0d errors=%0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hdl/isa_pkg.sv
hdl/core_pkg.sv
hdl/decode_stage.sv
hdl/map_table.sv
hdl/free_list.sv
hdl/rename_stage.sv
hdl/dispatch_stage.sv
hdl/dispatch_top.sv
test/dispatch_asserts.sv
test/tb_dispatch.sv

// File: run.sh
#!/bin/sh
# Verilator build and run of the rename and dispatch testbench
# Exit status is non-zero on a build error or a reported failure

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_dispatch -o sim_dispatch \
    && ./obj_dir/sim_dispatch > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Verification failed" sim.log && { echo "simulation reported a failure"; exit 1; } \
    || echo "simulation log clean"
